// ==== rtl/socBusPkg.sv ====
// address map and register constants are fixed here; region sizes must stay powers of two
package socBusPkg;

    // bus widths
    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;

    // address map, base and size in bytes
    localparam logic [AddrWidth-1:0] RamBase    = 32'h00000000;
    localparam logic [AddrWidth-1:0] RamSize    = 32'h1000;
    localparam logic [AddrWidth-1:0] RandomBase = 32'h00005000;
    localparam logic [AddrWidth-1:0] RandomSize = 32'h4;
    localparam logic [AddrWidth-1:0] TimerBase  = 32'h00005100;
    localparam logic [AddrWidth-1:0] TimerSize  = 32'h10;
    localparam logic [AddrWidth-1:0] SlowBase   = 32'h01000000;
    localparam logic [AddrWidth-1:0] SlowSize   = 32'h1000;

    // word index widths seen by each slave
    localparam int RamWordBits   = $clog2(RamSize / 4);
    localparam int TimerWordBits = $clog2(TimerSize / 4);
    localparam int SlowWordBits  = $clog2(SlowSize / 4);

    // timer register word indices
    localparam logic [TimerWordBits-1:0] TimerCtrl   = 2'd0;
    localparam logic [TimerWordBits-1:0] TimerPeriod = 2'd1;
    localparam logic [TimerWordBits-1:0] TimerCount  = 2'd2;
    localparam logic [TimerWordBits-1:0] TimerStatus = 2'd3;

    // galois lfsr feedback taps and reset state
    localparam logic [DataWidth-1:0] LfsrMask = 32'h80200003;
    localparam logic [DataWidth-1:0] LfsrSeed = 32'h00000001;

    // inclusive range check used by the address decoder
    function automatic logic inRegion(
        input logic [AddrWidth-1:0] address,
        input logic [AddrWidth-1:0] base,
        input logic [AddrWidth-1:0] size
    );
        inRegion = (address >= base) && (address <= (base + (size - 1)));
    endfunction

endpackage

// ==== rtl/busArbiter.sv ====
// two masters only; one read outstanding at a time, stalled requests keep their grant
`timescale 1ns/1ps

module busArbiter import socBusPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [AddrWidth-1:0] m0Address,
    input  logic                 m0Read,
    input  logic                 m0Write,
    input  logic [DataWidth-1:0] m0WriteData,
    output logic                 m0WaitRequest,
    output logic                 m0ReadValid,
    output logic [DataWidth-1:0] m0ReadData,
    input  logic [AddrWidth-1:0] m1Address,
    input  logic                 m1Read,
    input  logic                 m1Write,
    input  logic [DataWidth-1:0] m1WriteData,
    output logic                 m1WaitRequest,
    output logic                 m1ReadValid,
    output logic [DataWidth-1:0] m1ReadData,
    output logic [AddrWidth-1:0] busAddress,
    output logic                 busRead,
    output logic                 busWrite,
    output logic [DataWidth-1:0] busWriteData,
    input  logic                 busWaitRequest,
    input  logic                 busReadValid,
    input  logic [DataWidth-1:0] busReadData
);

    logic m0Req;
    logic m1Req;
    logic grant;
    logic ownerQ;
    logic lastWinner;
    logic lockRead;
    logic holdGrant;

    assign m0Req = m0Read | m0Write;
    assign m1Req = m1Read | m1Write;

    always_comb begin
        // keep the owner while a read is in flight or a request is stalled
        if (lockRead || holdGrant) begin
            grant = ownerQ;
        end else if (m0Req && m1Req) begin
            grant = ~lastWinner;
        end else begin
            grant = m1Req;
        end
    end

    // no new strobe reaches the bus until the outstanding read returns
    assign busAddress   = grant ? m1Address : m0Address;
    assign busWriteData = grant ? m1WriteData : m0WriteData;
    assign busRead      = !lockRead && (grant ? m1Read : m0Read);
    assign busWrite     = !lockRead && (grant ? m1Write : m0Write);

    assign m0WaitRequest = (!grant && !lockRead) ? busWaitRequest : 1'b1;
    assign m1WaitRequest = (grant && !lockRead) ? busWaitRequest : 1'b1;

    // response goes only to the read owner
    assign m0ReadValid = busReadValid && lockRead && !ownerQ;
    assign m1ReadValid = busReadValid && lockRead && ownerQ;
    assign m0ReadData  = busReadData;
    assign m1ReadData  = busReadData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ownerQ     <= 1'b0;
            lastWinner <= 1'b1;
            lockRead   <= 1'b0;
            holdGrant  <= 1'b0;
        end else begin
            ownerQ    <= grant;
            holdGrant <= (busRead || busWrite) && busWaitRequest;
            if ((busRead || busWrite) && !busWaitRequest) begin
                lastWinner <= grant;
            end
            if (busRead && !busWaitRequest) begin
                lockRead <= 1'b1;
            end else if (busReadValid) begin
                lockRead <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/socInterconnect.sv ====
// fixed four-slave map; unmapped reads return zero a cycle later, unmapped writes are dropped
`timescale 1ns/1ps

module socInterconnect import socBusPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [AddrWidth-1:0]     busAddress,
    input  logic                     busRead,
    input  logic                     busWrite,
    output logic                     busWaitRequest,
    output logic                     busReadValid,
    output logic [DataWidth-1:0]     busReadData,

    output logic                     ramRead,
    output logic                     ramWrite,
    output logic [RamWordBits-1:0]   ramAddress,
    input  logic [DataWidth-1:0]     ramData,
    input  logic                     ramValid,

    output logic                     randomRead,
    output logic                     randomWrite,
    input  logic [DataWidth-1:0]     randomData,
    input  logic                     randomValid,

    output logic                     timerRead,
    output logic                     timerWrite,
    output logic [TimerWordBits-1:0] timerAddress,
    input  logic [DataWidth-1:0]     timerData,
    input  logic                     timerValid,

    output logic                     slowRead,
    output logic                     slowWrite,
    output logic [SlowWordBits-1:0]  slowAddress,
    input  logic [DataWidth-1:0]     slowData,
    input  logic                     slowValid,
    input  logic                     slowWaitRequest
);

    logic ramHit;
    logic randomHit;
    logic timerHit;
    logic slowHit;
    logic unmappedHit;
    logic unmappedPending;
    logic [3:0] validBus;

    always_comb begin
        ramHit      = inRegion(busAddress, RamBase, RamSize);
        randomHit   = inRegion(busAddress, RandomBase, RandomSize);
        timerHit    = inRegion(busAddress, TimerBase, TimerSize);
        slowHit     = inRegion(busAddress, SlowBase, SlowSize);
        unmappedHit = !(ramHit || randomHit || timerHit || slowHit);
    end

    // strobes only reach the slave that was hit
    always_comb begin
        ramRead     = busRead && ramHit;
        ramWrite    = busWrite && ramHit;
        randomRead  = busRead && randomHit;
        randomWrite = busWrite && randomHit;
        timerRead   = busRead && timerHit;
        timerWrite  = busWrite && timerHit;
        slowRead    = busRead && slowHit;
        slowWrite   = busWrite && slowHit;

        // word index from bit 2 up
        ramAddress   = busAddress[RamWordBits+1:2];
        timerAddress = busAddress[TimerWordBits+1:2];
        slowAddress  = busAddress[SlowWordBits+1:2];

        // only the slow memory stretches an access
        busWaitRequest = slowHit ? slowWaitRequest : 1'b0;
    end

    // unmapped reads never stall, so the strobe is the acceptance
    always_ff @(posedge clk) begin
        if (!rstN) begin
            unmappedPending <= 1'b0;
        end else begin
            unmappedPending <= busRead && unmappedHit;
        end
    end

    always_comb begin
        validBus = {ramValid, randomValid, timerValid, slowValid};

        case (validBus)
            4'b1000: busReadData = ramData;
            4'b0100: busReadData = randomData;
            4'b0010: busReadData = timerData;
            4'b0001: busReadData = slowData;
            // unmapped response lands here as zero
            default: busReadData = '0;
        endcase

        busReadValid = (|validBus) || unmappedPending;
    end

endmodule

// ==== rtl/scratchRam.sv ====
// single-port word RAM, no byte enables; read data is registered one cycle after the strobe
`timescale 1ns/1ps

module scratchRam import socBusPkg::*; #(
    parameter int RamAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   read,
    input  logic                   write,
    input  logic [RamAddrBits-1:0] address,
    input  logic [DataWidth-1:0]   writeData,
    output logic [DataWidth-1:0]   readData,
    output logic                   readValid
);

    logic [DataWidth-1:0] mem [2**RamAddrBits];

    // storage, no reset
    always_ff @(posedge clk) begin
        if (write) begin
            mem[address] <= writeData;
        end
        if (read) begin
            readData <= mem[address];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= read;
        end
    end

endmodule

// ==== rtl/randomGen.sv ====
// 32-bit galois lfsr, steps only on reads; a zero seed is replaced by one
`timescale 1ns/1ps

module randomGen import socBusPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 read,
    input  logic                 write,
    input  logic [DataWidth-1:0] writeData,
    output logic [DataWidth-1:0] readData,
    output logic                 readValid
);

    logic [DataWidth-1:0] state;
    logic [DataWidth-1:0] nextState;

    // one right shift, taps folded in when a one falls out
    assign nextState = {1'b0, state[DataWidth-1:1]} ^ (state[0] ? LfsrMask : '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= LfsrSeed;
            readValid <= 1'b0;
            readData  <= '0;
        end else begin
            readValid <= read;
            if (write) begin
                state <= (writeData == '0) ? LfsrSeed : writeData;
            end else if (read) begin
                readData <= state;
                state    <= nextState;
            end
        end
    end

endmodule

// ==== rtl/intervalTimer.sv ====
// free-running period timer; count is read only and a period of zero wraps at all ones
`timescale 1ns/1ps

module intervalTimer import socBusPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     read,
    input  logic                     write,
    input  logic [TimerWordBits-1:0] address,
    input  logic [DataWidth-1:0]     writeData,
    output logic [DataWidth-1:0]     readData,
    output logic                     readValid,
    output logic                     timerIrq
);

    logic                 enable;
    logic                 flag;
    logic [DataWidth-1:0] period;
    logic [DataWidth-1:0] count;
    logic                 expire;

    assign expire   = enable && (count == period - 1'b1);
    assign timerIrq = flag;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            enable    <= 1'b0;
            flag      <= 1'b0;
            period    <= '0;
            count     <= '0;
            readValid <= 1'b0;
            readData  <= '0;
        end else begin
            readValid <= read;

            if (expire) begin
                count <= '0;
            end else if (enable) begin
                count <= count + 1'b1;
            end

            // a fresh expiry beats a clear in the same cycle
            if (expire) begin
                flag <= 1'b1;
            end else if (write && address == TimerStatus) begin
                flag <= 1'b0;
            end

            if (write && address == TimerCtrl) begin
                enable <= writeData[0];
                count  <= '0;
            end
            if (write && address == TimerPeriod) begin
                period <= writeData;
            end

            if (read) begin
                case (address)
                    TimerCtrl:   readData <= {{(DataWidth-1){1'b0}}, enable};
                    TimerPeriod: readData <= period;
                    TimerCount:  readData <= count;
                    default:     readData <= {{(DataWidth-1){1'b0}}, flag};
                endcase
            end
        end
    end

endmodule

// ==== rtl/slowMemory.sv ====
// word RAM with a fixed WaitStates stall per access; the request must hold steady while stalled
`timescale 1ns/1ps

module slowMemory import socBusPkg::*; #(
    parameter int RamAddrBits = 10,
    parameter int WaitStates  = 3
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   read,
    input  logic                   write,
    input  logic [RamAddrBits-1:0] address,
    input  logic [DataWidth-1:0]   writeData,
    output logic                   waitRequest,
    output logic [DataWidth-1:0]   readData,
    output logic                   readValid
);

    localparam int CountBits = $clog2(WaitStates + 2);

    logic [DataWidth-1:0] mem [2**RamAddrBits];
    logic [CountBits-1:0] waitCount;
    logic                 request;
    logic                 accept;

    assign request     = read | write;
    assign waitRequest = request && (waitCount != CountBits'(WaitStates));
    assign accept      = request && !waitRequest;

    // counts stall cycles, back to zero once the access goes through
    always_ff @(posedge clk) begin
        if (!rstN) begin
            waitCount <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= read && accept;
            if (!request || accept) begin
                waitCount <= '0;
            end else begin
                waitCount <= waitCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write && accept) begin
            mem[address] <= writeData;
        end
        if (read && accept) begin
            readData <= mem[address];
        end
    end

endmodule

// ==== rtl/socBusTop.sv ====
// RamAddrBits must match the 1024-word RAM and slow regions of the address map
`timescale 1ns/1ps

module socBusTop import socBusPkg::*; #(
    parameter int RamAddrBits = 10,
    parameter int WaitStates  = 3
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [AddrWidth-1:0] m0Address,
    input  logic                 m0Read,
    input  logic                 m0Write,
    input  logic [DataWidth-1:0] m0WriteData,
    output logic                 m0WaitRequest,
    output logic                 m0ReadValid,
    output logic [DataWidth-1:0] m0ReadData,
    input  logic [AddrWidth-1:0] m1Address,
    input  logic                 m1Read,
    input  logic                 m1Write,
    input  logic [DataWidth-1:0] m1WriteData,
    output logic                 m1WaitRequest,
    output logic                 m1ReadValid,
    output logic [DataWidth-1:0] m1ReadData,
    output logic                 timerIrq
);

    // shared bus after arbitration
    logic [AddrWidth-1:0] busAddress;
    logic                 busRead;
    logic                 busWrite;
    logic [DataWidth-1:0] busWriteData;
    logic                 busWaitRequest;
    logic                 busReadValid;
    logic [DataWidth-1:0] busReadData;

    // per-slave strobes and returns
    logic ramRead, ramWrite, ramValid;
    logic randomRead, randomWrite, randomValid;
    logic timerRead, timerWrite, timerValid;
    logic slowRead, slowWrite, slowValid, slowWaitRequest;
    logic [RamAddrBits-1:0]   ramAddress;
    logic [TimerWordBits-1:0] timerAddress;
    logic [RamAddrBits-1:0]   slowAddress;
    logic [DataWidth-1:0]     ramData, randomData, timerData, slowData;

    busArbiter arbiter0 (.*);

    socInterconnect interconnect0 (.*);

    scratchRam #(.RamAddrBits(RamAddrBits)) ram0 (
        .clk, .rstN, .read(ramRead), .write(ramWrite), .address(ramAddress),
        .writeData(busWriteData), .readData(ramData), .readValid(ramValid)
    );

    randomGen random0 (
        .clk, .rstN, .read(randomRead), .write(randomWrite),
        .writeData(busWriteData), .readData(randomData), .readValid(randomValid)
    );

    intervalTimer timer0 (
        .clk, .rstN, .read(timerRead), .write(timerWrite), .address(timerAddress),
        .writeData(busWriteData), .readData(timerData), .readValid(timerValid),
        .timerIrq
    );

    slowMemory #(.RamAddrBits(RamAddrBits), .WaitStates(WaitStates)) slow0 (
        .clk, .rstN, .read(slowRead), .write(slowWrite), .address(slowAddress),
        .writeData(busWriteData), .waitRequest(slowWaitRequest),
        .readData(slowData), .readValid(slowValid)
    );

endmodule

// ==== verif/clockGen.sv ====
// free-running clock with a power-on reset that is released on a falling edge
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod  = 50,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #HalfPeriod clk = ~clk;
        end
    end

    // low across ResetCycles rising edges
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// ==== verif/socBusTb.sv ====
// assumes the default DUT parameters (three slow wait states); the run stops at the first error
`timescale 1ns/1ps

module socBusTb import socBusPkg::*; ();

    localparam int SlowWaits  = 3;
    localparam int MaxWait    = 40;
    localparam int SettleTime = 10;

    logic                 clk;
    logic                 rstN;
    logic [AddrWidth-1:0] address [2];
    logic [DataWidth-1:0] writeData [2];
    logic [DataWidth-1:0] readData [2];
    logic [1:0]           readReq;
    logic [1:0]           writeReq;
    logic [1:0]           waitRequest;
    logic [1:0]           readValid;
    logic                 timerIrq;
    int                   cycleCount = 0;
    // arbiter resets as if master 1 won last
    int                   lastAccepted = 1;

    clockGen clockGen0 (.clk, .rstN);

    socBusTop dut0 (
        .clk, .rstN,
        .m0Address(address[0]), .m0Read(readReq[0]), .m0Write(writeReq[0]),
        .m0WriteData(writeData[0]), .m0WaitRequest(waitRequest[0]),
        .m0ReadValid(readValid[0]), .m0ReadData(readData[0]),
        .m1Address(address[1]), .m1Read(readReq[1]), .m1Write(writeReq[1]),
        .m1WriteData(writeData[1]), .m1WaitRequest(waitRequest[1]),
        .m1ReadValid(readValid[1]), .m1ReadData(readData[1]),
        .timerIrq
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEqual(input string name, input logic [DataWidth-1:0] actual,
                              input logic [DataWidth-1:0] expected);
        if (actual !== expected) begin
            stopWithError($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    // one right shift with the taps folded in when a one drops out
    function automatic logic [DataWidth-1:0] galoisStep(input logic [DataWidth-1:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'h80200003;
        end
        return value >> 1;
    endfunction

    function automatic logic [AddrWidth-1:0] timerAddr(input logic [TimerWordBits-1:0] index);
        return TimerBase + (AddrWidth'(index) << 2);
    endfunction

    // returns at the sample just before the accepting edge
    task automatic waitAccept(input int master, output int waits, output int acceptCycle);
        waits = 0;
        #SettleTime;
        while (waitRequest[master]) begin
            waits++;
            if (waits > MaxWait) begin
                stopWithError($sformatf("master %0d request was never accepted", master));
            end
            @(negedge clk);
            #SettleTime;
        end
        acceptCycle = cycleCount;
        lastAccepted = master;
    endtask

    task automatic busWrite(input int master, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data, output int waits,
                            output int acceptCycle);
        @(negedge clk);
        address[master] = addr;
        writeData[master] = data;
        writeReq[master] = 1'b1;
        waitAccept(master, waits, acceptCycle);
        @(negedge clk);
        writeReq[master] = 1'b0;
    endtask

    task automatic busRead(input int master, input logic [AddrWidth-1:0] addr,
                           output logic [DataWidth-1:0] data, output int waits,
                           output int latency, output int acceptCycle);
        @(negedge clk);
        address[master] = addr;
        readReq[master] = 1'b1;
        waitAccept(master, waits, acceptCycle);
        @(negedge clk);
        readReq[master] = 1'b0;
        latency = 1;
        #SettleTime;
        while (!readValid[master]) begin
            latency++;
            if (latency > MaxWait) begin
                stopWithError($sformatf("master %0d read got no readValid", master));
            end
            @(negedge clk);
            #SettleTime;
        end
        data = readData[master];
    endtask

    // on a tie the master that did not win last must go first
    task automatic checkAlternation(input int expectWinner, input int accept0, input int accept1);
        checkEqual("grant cycles differ", accept0 != accept1, 1'b1);
        checkEqual("tie winner", (accept0 < accept1) ? 0 : 1, expectWinner);
    endtask

    task automatic ramReadback();
        logic [DataWidth-1:0] words [8];
        logic [AddrWidth-1:0] addrs [8];
        logic [DataWidth-1:0] data;
        int start;
        int waits;
        int latency;
        int acceptCycle;
        start = $urandom % 1024;
        // stride keeps the eight word indices distinct
        for (int i = 0; i < 8; i++) begin
            addrs[i] = RamBase + 32'(((start + i * 37) % 1024) * 4);
            words[i] = $urandom;
            busWrite(0, addrs[i], words[i], waits, acceptCycle);
        end
        for (int i = 0; i < 8; i++) begin
            busRead(1, addrs[i], data, waits, latency, acceptCycle);
            checkEqual("m1ReadData", data, words[i]);
            checkEqual("m1ReadValid latency", latency, 1);
        end
    endtask

    task automatic slowWaitStates();
        logic [DataWidth-1:0] words [4];
        logic [AddrWidth-1:0] addrs [4];
        logic [DataWidth-1:0] data;
        int waits;
        int latency;
        int acceptCycle;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = SlowBase + 32'((($urandom % 256) + i * 256) * 4);
            words[i] = $urandom;
            busWrite(0, addrs[i], words[i], waits, acceptCycle);
            checkEqual("m0WaitRequest cycles", waits, SlowWaits);
        end
        for (int i = 0; i < 4; i++) begin
            busRead(1, addrs[i], data, waits, latency, acceptCycle);
            checkEqual("m1WaitRequest cycles", waits, SlowWaits);
            checkEqual("m1ReadData", data, words[i]);
        end
    endtask

    task automatic randomSequence();
        logic [DataWidth-1:0] model;
        logic [DataWidth-1:0] data;
        int waits;
        int latency;
        int acceptCycle;
        model = $urandom;
        busWrite(0, RandomBase, model, waits, acceptCycle);
        if (model == '0) begin
            model = 32'h1;
        end
        for (int i = 0; i < 6; i++) begin
            busRead(0, RandomBase, data, waits, latency, acceptCycle);
            checkEqual("random readData", data, model);
            model = galoisStep(model);
        end
        busWrite(1, RandomBase, '0, waits, acceptCycle);
        busRead(1, RandomBase, data, waits, latency, acceptCycle);
        checkEqual("random after zero seed", data, 32'h1);
    endtask

    task automatic timerInterrupt();
        logic [DataWidth-1:0] period;
        logic [DataWidth-1:0] data;
        int polls;
        int waits;
        int latency;
        int acceptCycle;
        period = 32'd16 + ($urandom % 16);
        busWrite(0, timerAddr(TimerPeriod), period, waits, acceptCycle);
        busWrite(0, timerAddr(TimerCtrl), 32'h1, waits, acceptCycle);
        polls = 0;
        data = '0;
        while (!data[0]) begin
            polls++;
            if (polls > MaxWait) begin
                stopWithError("timer status flag never got set");
            end
            busRead(1, timerAddr(TimerStatus), data, waits, latency, acceptCycle);
        end
        checkEqual("timerIrq", timerIrq, 1'b1);
        busRead(0, timerAddr(TimerCount), data, waits, latency, acceptCycle);
        checkEqual("TimerCount below period", data < period, 1'b1);
        // stopped first so a new expiry cannot land on the clear
        busWrite(0, timerAddr(TimerCtrl), 32'h0, waits, acceptCycle);
        busWrite(0, timerAddr(TimerStatus), 32'h1, waits, acceptCycle);
        checkEqual("timerIrq", timerIrq, 1'b0);
    endtask

    task automatic contention();
        logic [AddrWidth-1:0] ramAddr;
        logic [AddrWidth-1:0] slowAddr;
        logic [DataWidth-1:0] ramWord;
        logic [DataWidth-1:0] slowWord;
        logic [DataWidth-1:0] data [2];
        int waits [2];
        int latency [2];
        int accept [2];
        int expectWinner;
        ramAddr = RamBase + 32'(($urandom % 1024) * 4);
        slowAddr = SlowBase + 32'(($urandom % 1024) * 4);
        ramWord = $urandom;
        slowWord = $urandom;
        expectWinner = 1 - lastAccepted;
        fork
            busWrite(0, ramAddr, ramWord, waits[0], accept[0]);
            busWrite(1, slowAddr, slowWord, waits[1], accept[1]);
        join
        checkAlternation(expectWinner, accept[0], accept[1]);
        // each master reads what the other wrote
        expectWinner = 1 - lastAccepted;
        fork
            busRead(0, slowAddr, data[0], waits[0], latency[0], accept[0]);
            busRead(1, ramAddr, data[1], waits[1], latency[1], accept[1]);
        join
        checkAlternation(expectWinner, accept[0], accept[1]);
        checkEqual("m0ReadData", data[0], slowWord);
        checkEqual("m1ReadData", data[1], ramWord);
        // master 1 alone, so the next tie goes to master 0
        busRead(1, ramAddr, data[1], waits[1], latency[1], accept[1]);
        checkEqual("m1ReadData", data[1], ramWord);
        // slow read racing a RAM write
        ramWord = ~ramWord;
        expectWinner = 1 - lastAccepted;
        fork
            busRead(0, slowAddr, data[0], waits[0], latency[0], accept[0]);
            busWrite(1, ramAddr, ramWord, waits[1], accept[1]);
        join
        checkAlternation(expectWinner, accept[0], accept[1]);
        checkEqual("m0ReadData", data[0], slowWord);
        expectWinner = 1 - lastAccepted;
        fork
            busRead(0, ramAddr, data[0], waits[0], latency[0], accept[0]);
            busRead(1, slowAddr, data[1], waits[1], latency[1], accept[1]);
        join
        checkAlternation(expectWinner, accept[0], accept[1]);
        checkEqual("m0ReadData", data[0], ramWord);
        checkEqual("m1ReadData", data[1], slowWord);
    endtask

    task automatic unmappedAccess();
        logic [AddrWidth-1:0] offset;
        logic [DataWidth-1:0] ramWord;
        logic [DataWidth-1:0] slowWord;
        logic [DataWidth-1:0] data;
        int waits;
        int latency;
        int acceptCycle;
        offset = 32'(($urandom % 1024) * 4);
        ramWord = $urandom;
        slowWord = $urandom;
        busWrite(0, RamBase + offset, ramWord, waits, acceptCycle);
        busWrite(0, SlowBase + offset, slowWord, waits, acceptCycle);
        // same low address bits as the RAM and slow words but outside every region
        busWrite(1, 32'h00003000 + offset, ~ramWord, waits, acceptCycle);
        busWrite(1, SlowBase + SlowSize + offset, ~slowWord, waits, acceptCycle);
        busRead(0, 32'h00002000 + offset, data, waits, latency, acceptCycle);
        checkEqual("unmapped m0ReadData", data, '0);
        checkEqual("unmapped m0ReadValid latency", latency, 1);
        busRead(1, RamBase + offset, data, waits, latency, acceptCycle);
        checkEqual("m1ReadData", data, ramWord);
        busRead(1, SlowBase + offset, data, waits, latency, acceptCycle);
        checkEqual("m1ReadData", data, slowWord);
    endtask

    initial begin
        int resetWait;
        void'($urandom(32'hdc5d2730));
        address[0] = '0;
        address[1] = '0;
        writeData[0] = '0;
        writeData[1] = '0;
        readReq = '0;
        writeReq = '0;
        resetWait = 0;
        while (rstN !== 1'b1) begin
            resetWait++;
            if (resetWait > MaxWait) begin
                stopWithError("reset was never released");
            end
            @(negedge clk);
        end
        ramReadback();
        slowWaitStates();
        randomSequence();
        timerInterrupt();
        contention();
        unmappedAccess();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/socBusPkg.sv
rtl/busArbiter.sv
rtl/socInterconnect.sv
rtl/scratchRam.sv
rtl/randomGen.sv
rtl/intervalTimer.sv
rtl/slowMemory.sv
rtl/socBusTop.sv
verif/clockGen.sv
verif/socBusTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module socBusTb -f filelist.f -o socBusSim

./obj_dir/socBusSim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
